//--- Bender.yml
package:
  name: dct2d

export_include_dirs:
  - .

sources:
  - dctPkg.sv
  - coefRom.sv
  - dctPass.sv
  - transposeBuffer.sv
  - dct2d.sv
  - target: test
    files:
      - tbDct2d.sv

//--- coefRom.sv
`timescale 1ns/10ps
`include "dct_macros.svh"

module coefRom (
  input  logic                       clk,
  input  logic [2:0]                 idx,
  output logic signed [`COEF_W-1:0]  coefs [`BLOCK_N/2]
);
  import dctPkg::*;

  // One row per frequency index k, four entries for n = 0..3
  logic signed [`COEF_W-1:0] coefTable [`BLOCK_N][`BLOCK_N/2];

  // ######################################################################
  // Table contents
  // ######################################################################

  // Even rows pair with sums and odd rows with differences, so only
  // the first half of each basis vector is stored
  initial begin
    for (int k = 0; k < `BLOCK_N; k++) begin
      for (int n = 0; n < `BLOCK_N / 2; n++) begin
        coefTable[k][n] = `COEF_W'(coefValue(k, n));
      end
    end
  end

  // ######################################################################
  // Registered read
  // ######################################################################

  always_ff @(posedge clk) begin
    coefs <= coefTable[idx];
  end

endmodule

//--- dct2d.sv
`timescale 1ns/10ps
`include "dct_macros.svh"

module dct2d (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dctPkg::samplePort_t  x,
  output dctPkg::coefPort_t    y
);
  import dctPkg::*;

  stagePort_t              z;
  stagePort_t              t;
  logic signed [`OUT_W-1:0] colData;
  logic                    colValid;

  // ######################################################################
  // Row pass, one 8-point transform per input row
  // ######################################################################

  dctPass #(
    .IN_W      (`SAMPLE_W),
    .OUT_WIDTH (`STAGE_W)
  ) rowPass (
    .clk      (clk),
    .rst_n    (rst_n),
    .inData   (x.data),
    .inValid  (x.valid),
    .outData  (z.data),
    .outValid (z.valid)
  );

  // Row results come back out column by column
  transposeBuffer tBuf (
    .clk   (clk),
    .rst_n (rst_n),
    .z     (z),
    .t     (t)
  );

  // ######################################################################
  // Column pass
  // ######################################################################

  dctPass #(
    .IN_W      (`STAGE_W),
    .OUT_WIDTH (`OUT_W)
  ) colPass (
    .clk      (clk),
    .rst_n    (rst_n),
    .inData   (t.data),
    .inValid  (t.valid),
    .outData  (colData),
    .outValid (colValid)
  );

  assign y.valid = colValid;
  assign y.data  = colData;

endmodule

//--- dctPass.sv
`timescale 1ns/10ps
`include "dct_macros.svh"

module dctPass #(
  parameter int IN_W      = `SAMPLE_W,
  parameter int OUT_WIDTH = `STAGE_W
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic signed [IN_W-1:0]      inData,
  input  logic                        inValid,
  output logic signed [OUT_WIDTH-1:0] outData,
  output logic                        outValid
);
  import dctPkg::*;

  localparam int HALF   = `BLOCK_N / 2;
  localparam int SUM_W  = IN_W + 1;
  localparam int PROD_W = `COEF_W + SUM_W;
  localparam int RND_W  = PROD_W - `COEF_FRAC;
  localparam int ACC_W  = RND_W + 2;
  localparam logic signed [PROD_W-1:0] ROUND_BIAS = PROD_W'(1 << (`COEF_FRAC - 1));

  logic signed [IN_W-1:0]    lineBuf [`BLOCK_N-1];
  logic signed [IN_W-1:0]    group [`BLOCK_N];
  logic [2:0]                inCnt;
  logic                      groupDone;
  logic signed [SUM_W-1:0]   holdSum [HALF];
  logic signed [SUM_W-1:0]   holdDiff [HALF];
  passState_t                state;
  logic [2:0]                kCnt;
  logic signed [`COEF_W-1:0] coefs [HALF];
  logic signed [SUM_W-1:0]   opReg [HALF];
  logic                      opValid;
  logic signed [PROD_W-1:0]  rawProd [HALF];
  logic signed [RND_W-1:0]   rndProd [HALF];
  logic signed [RND_W-1:0]   prodReg [HALF];
  logic                      prodValid;
  logic signed [ACC_W-1:0]   accSum;

  // ######################################################################
  // Line capture
  // ######################################################################

  assign groupDone = inValid && (inCnt == 3'(`BLOCK_N - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inCnt <= '0;
    end else if (inValid) begin
      inCnt <= inCnt + 3'd1;
    end
  end

  // Newest sample sits in lineBuf[0]
  always_ff @(posedge clk) begin
    if (inValid) begin
      lineBuf[0] <= inData;
      for (int i = 1; i < `BLOCK_N - 1; i++) begin
        lineBuf[i] <= lineBuf[i-1];
      end
    end
  end

  // The eighth sample joins the group straight from the input
  always_comb begin
    for (int n = 0; n < `BLOCK_N - 1; n++) begin
      group[n] = lineBuf[`BLOCK_N-2-n];
    end
    group[`BLOCK_N-1] = inData;
  end

  // Butterfly into the holding register, free for the next line right away
  always_ff @(posedge clk) begin
    if (groupDone) begin
      for (int n = 0; n < HALF; n++) begin
        holdSum[n]  <= SUM_W'(group[n]) + SUM_W'(group[`BLOCK_N-1-n]);
        holdDiff[n] <= SUM_W'(group[n]) - SUM_W'(group[`BLOCK_N-1-n]);
      end
    end
  end

  // ######################################################################
  // Output sequencer
  // ######################################################################

  // A new group restarts k at 0 even if the previous one just ended
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= PASS_IDLE;
      kCnt  <= '0;
    end else if (groupDone) begin
      state <= PASS_EMIT;
      kCnt  <= '0;
    end else if (state == PASS_EMIT) begin
      kCnt <= kCnt + 3'd1;
      if (kCnt == 3'(`BLOCK_N - 1)) begin
        state <= PASS_IDLE;
      end
    end
  end

  coefRom rom (
    .clk   (clk),
    .idx   (kCnt),
    .coefs (coefs)
  );

  // ######################################################################
  // Multiply and accumulate
  // ######################################################################

  // Odd frequencies use the differences, lines up with the ROM latency
  always_ff @(posedge clk) begin
    for (int n = 0; n < HALF; n++) begin
      opReg[n] <= kCnt[0] ? holdDiff[n] : holdSum[n];
    end
  end

  always_comb begin
    for (int n = 0; n < HALF; n++) begin
      rawProd[n] = PROD_W'(coefs[n]) * PROD_W'(opReg[n]) + ROUND_BIAS;
      rndProd[n] = rawProd[n][PROD_W-1:`COEF_FRAC];
    end
  end

  always_ff @(posedge clk) begin
    prodReg <= rndProd;
  end

  always_comb begin
    accSum = '0;
    for (int n = 0; n < HALF; n++) begin
      accSum = accSum + ACC_W'(prodReg[n]);
    end
  end

  always_ff @(posedge clk) begin
    if (prodValid) begin
      outData <= accSum[OUT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opValid   <= 1'b0;
      prodValid <= 1'b0;
      outValid  <= 1'b0;
    end else begin
      opValid   <= (state == PASS_EMIT);
      prodValid <= opValid;
      outValid  <= prodValid;
    end
  end

endmodule

//--- dctPkg.sv
`include "dct_macros.svh"

package dctPkg;

  // ######################################################################
  // Stream ports
  // ######################################################################

  // Pixel stream into the row pass
  typedef struct packed {
    logic                        valid;
    logic signed [`SAMPLE_W-1:0] data;
  } samplePort_t;

  // Intermediate stream between the passes
  typedef struct packed {
    logic                       valid;
    logic signed [`STAGE_W-1:0] data;
  } stagePort_t;

  // Final coefficient stream, column-major
  typedef struct packed {
    logic                     valid;
    logic signed [`OUT_W-1:0] data;
  } coefPort_t;

  // ######################################################################
  // Control encodings
  // ######################################################################

  typedef enum logic [1:0] {
    PASS_IDLE = 2'd0,
    PASS_EMIT = 2'd1
  } passState_t;

  typedef enum logic [1:0] {
    BANK_FREE     = 2'd0,
    BANK_FILLING  = 2'd1,
    BANK_DRAINING = 2'd2
  } bankState_t;

  // ######################################################################
  // Coefficients
  // ######################################################################

  localparam real PI = 3.14159265358979323846;

  // Scaled DCT-II basis value c(k,n), halved so a 1-D pass has gain 1/2 per axis
  function automatic int coefValue(int k, int n);
    real scale;
    real angle;
    real value;
    scale = (k == 0) ? 1.0 / $sqrt(2.0) : 1.0;
    angle = real'((2 * n + 1) * k) * PI / real'(2 * `BLOCK_N);
    value = real'(1 << `COEF_FRAC) * scale * $cos(angle) / 2.0;
    // Conversion to int rounds to the nearest integer
    return int'(value);
  endfunction

endpackage

//--- dct_macros.svh
`ifndef DCT_MACROS_SVH
`define DCT_MACROS_SVH

// ######################################################################
// Block geometry
// ######################################################################

// Points per line of the 8x8 transform
`define BLOCK_N 8

// Samples per block
`define BLOCK_SIZE 64

// ######################################################################
// Datapath widths
// ######################################################################

// Signed input pixel
`define SAMPLE_W 8

// Signed cosine coefficient with COEF_FRAC fractional bits
`define COEF_W 10
`define COEF_FRAC 9

// Row pass results and final 2-D coefficients
`define STAGE_W 12
`define OUT_W 14

`endif

//--- list.f
+incdir+.
dctPkg.sv
coefRom.sv
dctPass.sv
transposeBuffer.sv
dct2d.sv
tbDct2d.sv

//--- tbDct2d.sv
`timescale 1ns/10ps
`include "dct_macros.svh"

module tbDct2d;
  import dctPkg::*;

  localparam int  CLK_PERIOD   = 100;
  localparam int  RESET_CYCLES = 16;
  localparam int  IDLE_CYCLES  = 20;
  localparam int  GAP_CYCLES   = 5;
  localparam int  TIMEOUT      = 400;
  localparam int  LATENCY      = 87;
  localparam int  NUM_BLOCKS   = 8;
  localparam real PI_TB        = 3.14159265358979323846;

  typedef enum logic [2:0] {
    PAT_CONST,
    PAT_RAMP,
    PAT_CHECKER,
    PAT_EXTREME,
    PAT_RANDOM
  } pattern_t;

  typedef enum logic [1:0] {
    DC_NEG,
    DC_ZERO,
    DC_POS,
    DC_ANY
  } dcSign_t;

  typedef struct packed {
    pattern_t                    kind;
    logic signed [`SAMPLE_W-1:0] param;
    logic                        backToBack;
    dcSign_t                     dcSign;
  } stimEntry_t;

  logic        clk;
  logic        rst_n;
  samplePort_t x;
  coefPort_t   y;

  stimEntry_t                  stimTable [NUM_BLOCKS];
  logic signed [`SAMPLE_W-1:0] blockIn [NUM_BLOCKS][`BLOCK_SIZE];
  logic signed [`OUT_W-1:0]    blockExp [NUM_BLOCKS][`BLOCK_SIZE];
  time                         xStart [NUM_BLOCKS];
  int                          coefTab [`BLOCK_N][`BLOCK_N/2];
  int                          lineIn [`BLOCK_N];
  int                          lineOut [`BLOCK_N];
  int                          blocksDone;
  integer                      seed;

  dct2d i_dct2d (
    .clk   (clk),
    .rst_n (rst_n),
    .x     (x),
    .y     (y)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ######################################################################
  // Stimulus table
  // ######################################################################

  task automatic loadStimTable();
    stimTable[0] = '{PAT_CONST,   8'sd37,   1'b0, DC_POS};
    stimTable[1] = '{PAT_CONST,   -8'sd60,  1'b0, DC_NEG};
    stimTable[2] = '{PAT_RAMP,    -8'sd60,  1'b0, DC_POS};
    stimTable[3] = '{PAT_CHECKER, 8'sd100,  1'b0, DC_ZERO};
    stimTable[4] = '{PAT_EXTREME, 8'sd0,    1'b0, DC_NEG};
    // Three random blocks where the last two follow with no gap
    stimTable[5] = '{PAT_RANDOM,  8'sd0,    1'b0, DC_ANY};
    stimTable[6] = '{PAT_RANDOM,  8'sd0,    1'b1, DC_ANY};
    stimTable[7] = '{PAT_RANDOM,  8'sd0,    1'b1, DC_ANY};
  endtask

  task automatic fillBlock(input int b);
    logic [31:0] rnd;
    int          r;
    int          c;
    int          value;
    for (int i = 0; i < `BLOCK_SIZE; i++) begin
      r = i / `BLOCK_N;
      c = i % `BLOCK_N;
      case (stimTable[b].kind)
        PAT_CONST:   value = $signed(stimTable[b].param);
        PAT_RAMP:    value = $signed(stimTable[b].param) + 2 * i;
        PAT_CHECKER: value = ((r + c) % 2 == 0) ? $signed(stimTable[b].param)
                                                : -$signed(stimTable[b].param);
        PAT_EXTREME: value = ((r + c) % 3 == 0) ? 127 : -128;
        default: begin
          rnd   = $random(seed);
          value = $signed(rnd[7:0]);
        end
      endcase
      blockIn[b][i] = `SAMPLE_W'(value);
    end
  endtask

  // ######################################################################
  // Reference model
  // ######################################################################

  function automatic int basisCoef(input int k, input int n);
    real scale;
    real value;
    scale = (k == 0) ? 1.0 / $sqrt(2.0) : 1.0;
    value = scale * $cos(real'((2 * n + 1) * k) * PI_TB / 16.0);
    value = value * real'(1 << `COEF_FRAC) / 2.0;
    if (value >= 0.0) begin
      return $rtoi(value + 0.5);
    end else begin
      return -$rtoi(0.5 - value);
    end
  endfunction

  function automatic int mulRound(input int c, input int a);
    return (c * a + (1 << (`COEF_FRAC - 1))) >>> `COEF_FRAC;
  endfunction

  task automatic loadCoefTable();
    for (int k = 0; k < `BLOCK_N; k++) begin
      for (int n = 0; n < `BLOCK_N / 2; n++) begin
        coefTab[k][n] = basisCoef(k, n);
      end
    end
  endtask

  // Even k takes the sums and odd k the differences of mirrored points
  task automatic dct1d();
    int acc;
    int operand;
    for (int k = 0; k < `BLOCK_N; k++) begin
      acc = 0;
      for (int n = 0; n < `BLOCK_N / 2; n++) begin
        if (k % 2 == 0) begin
          operand = lineIn[n] + lineIn[`BLOCK_N-1-n];
        end else begin
          operand = lineIn[n] - lineIn[`BLOCK_N-1-n];
        end
        acc += mulRound(coefTab[k][n], operand);
      end
      lineOut[k] = acc;
    end
  endtask

  task automatic modelBlock(input int b);
    int rowRes [`BLOCK_N][`BLOCK_N];
    for (int r = 0; r < `BLOCK_N; r++) begin
      for (int n = 0; n < `BLOCK_N; n++) begin
        lineIn[n] = blockIn[b][r * `BLOCK_N + n];
      end
      dct1d();
      for (int k = 0; k < `BLOCK_N; k++) begin
        rowRes[r][k] = lineOut[k];
      end
    end
    // The output stream is column-major with index k * 8 + u
    for (int k = 0; k < `BLOCK_N; k++) begin
      for (int r = 0; r < `BLOCK_N; r++) begin
        lineIn[r] = rowRes[r][k];
      end
      dct1d();
      for (int u = 0; u < `BLOCK_N; u++) begin
        blockExp[b][k * `BLOCK_N + u] = `OUT_W'(lineOut[u]);
      end
    end
  endtask

  // ######################################################################
  // Checks
  // ######################################################################

  task automatic stopWithFailure();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic string signText(input dcSign_t s);
    case (s)
      DC_NEG:  return "negative";
      DC_ZERO: return "zero";
      DC_POS:  return "positive";
      default: return "any";
    endcase
  endfunction

  task automatic checkCoef(input int b, input int j, input coefPort_t got,
                           input coefPort_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: block %0d index %0d got %0d (valid %0b) expected %0d",
               $time, b, j, $signed(got.data), got.valid, $signed(exp.data));
      stopWithFailure();
    end
  endtask

  task automatic checkDcSign(input int b, input coefPort_t got, input dcSign_t want);
    dcSign_t seen;
    if ($signed(got.data) < 0) begin
      seen = DC_NEG;
    end else if ($signed(got.data) == 0) begin
      seen = DC_ZERO;
    end else begin
      seen = DC_POS;
    end
    if (want != DC_ANY && seen != want) begin
      $display("Mismatch at %0d ns: block %0d DC term %0d is %s, expected %s",
               $time, b, $signed(got.data), signText(seen), signText(want));
      stopWithFailure();
    end
  endtask

  task automatic checkLatency(input int b, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0d ns: block %0d first output after %0d cycles, expected %0d",
               $time, b, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic checkValidRun(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("Output valid for %s was high for %0d cycles instead of %0d",
               what, got, exp);
      stopWithFailure();
    end
  endtask

  // ######################################################################
  // Waits
  // ######################################################################

  task automatic waitBlocksDone(input int target);
    int cycles;
    cycles = 0;
    while (blocksDone < target && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (blocksDone < target) begin
      $display("Timed out after %0d cycles waiting for block %0d to leave the DUT",
               TIMEOUT, target - 1);
      stopWithFailure();
    end
  endtask

  task automatic waitOutputValid(input int b);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!y.valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!y.valid) begin
      $display("Timed out after %0d cycles waiting for the first output of block %0d",
               TIMEOUT, b);
      stopWithFailure();
    end
  endtask

  // ######################################################################
  // Driver and monitor
  // ######################################################################

  function automatic bit lastOfBurst(input int b);
    if (b == NUM_BLOCKS - 1) begin
      return 1'b1;
    end else begin
      return !stimTable[b + 1].backToBack;
    end
  endfunction

  task automatic sendBlock(input int b);
    samplePort_t s;
    for (int i = 0; i < `BLOCK_SIZE; i++) begin
      @(posedge clk);
      if (i == 0) begin
        xStart[b] = $time;
      end
      s.valid = 1'b1;
      s.data  = blockIn[b][i];
      x <= s;
    end
  endtask

  task automatic driveStream();
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      if (!stimTable[b].backToBack) begin
        waitBlocksDone(b);
        repeat (GAP_CYCLES) @(posedge clk);
      end
      sendBlock(b);
      if (lastOfBurst(b)) begin
        @(posedge clk);
        x <= '0;
      end
    end
  endtask

  task automatic receiveBlock(input int b);
    coefPort_t exp;
    time       firstTime;
    int        run;
    bit        runOk;
    int        j;
    waitOutputValid(b);
    firstTime = $time;
    checkLatency(b, int'((firstTime - xStart[b] - CLK_PERIOD / 2) / CLK_PERIOD), LATENCY);
    run   = 0;
    runOk = 1'b1;
    j     = 0;
    while (runOk && j < `BLOCK_SIZE) begin
      if (j > 0) begin
        @(negedge clk);
      end
      if (y.valid) begin
        exp.valid = 1'b1;
        // A flat block has no AC energy at all
        if (stimTable[b].kind == PAT_CONST && j != 0) begin
          exp.data = '0;
        end else begin
          exp.data = blockExp[b][j];
        end
        checkCoef(b, j, y, exp);
        if (j == 0) begin
          checkDcSign(b, y, stimTable[b].dcSign);
        end
        run++;
        j++;
      end else begin
        runOk = 1'b0;
      end
    end
    if (runOk && lastOfBurst(b)) begin
      @(negedge clk);
      if (y.valid !== 1'b0) begin
        run++;
      end
    end
    checkValidRun($sformatf("block %0d", b), run, `BLOCK_SIZE);
    blocksDone++;
  endtask

  task automatic collectStream();
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      receiveBlock(b);
    end
  endtask

  task automatic checkIdle();
    int seen;
    seen = 0;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clk);
      if (y.valid !== 1'b0) begin
        seen++;
      end
    end
    checkValidRun("the idle time after reset", seen, 0);
  endtask

  // ######################################################################
  // Main sequence
  // ######################################################################

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    x          = '0;
    blocksDone = 0;
    seed       = 32'h8b60f006;
    loadStimTable();
    loadCoefTable();
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      fillBlock(b);
      modelBlock(b);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    checkIdle();
    fork
      driveStream();
      collectStream();
    join
    $display("No errors");
    $finish;
  end

endmodule

//--- transposeBuffer.sv
`timescale 1ns/10ps
`include "dct_macros.svh"

module transposeBuffer (
  input  logic                clk,
  input  logic                rst_n,
  input  dctPkg::stagePort_t  z,
  output dctPkg::stagePort_t  t
);
  import dctPkg::*;

  logic signed [`STAGE_W-1:0] bankMem [2][`BLOCK_SIZE];
  bankState_t                 bankState [2];
  logic                       wrBank;
  logic                       rdBank;
  logic [5:0]                 wrPtr;
  logic [5:0]                 rdPtr;
  logic [5:0]                 rdAddr;
  logic                       wrEn;
  logic                       wrLast;
  logic                       rdEn;
  logic                       rdLast;
  logic                       tValid;
  logic signed [`STAGE_W-1:0] tData;

  // ######################################################################
  // Bank control
  // ######################################################################

  // A bank that is still being read never takes writes
  assign wrEn   = z.valid && (bankState[wrBank] != BANK_DRAINING);
  assign wrLast = wrEn && (wrPtr == 6'(`BLOCK_SIZE - 1));
  assign rdEn   = (bankState[rdBank] == BANK_DRAINING);
  assign rdLast = rdEn && (rdPtr == 6'(`BLOCK_SIZE - 1));

  // rdPtr holds {k, r}, the store is addressed {r, k}
  assign rdAddr = {rdPtr[2:0], rdPtr[5:3]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrBank       <= 1'b0;
      rdBank       <= 1'b0;
      wrPtr        <= '0;
      rdPtr        <= '0;
      bankState[0] <= BANK_FREE;
      bankState[1] <= BANK_FREE;
      tValid       <= 1'b0;
    end else begin
      if (wrEn) begin
        wrPtr <= wrPtr + 6'd1;
        if (wrLast) begin
          bankState[wrBank] <= BANK_DRAINING;
          wrBank            <= ~wrBank;
        end else begin
          bankState[wrBank] <= BANK_FILLING;
        end
      end
      if (rdEn) begin
        rdPtr <= rdPtr + 6'd1;
        if (rdLast) begin
          bankState[rdBank] <= BANK_FREE;
          rdBank            <= ~rdBank;
        end
      end
      tValid <= rdEn;
    end
  end

  // ######################################################################
  // Storage
  // ######################################################################

  always_ff @(posedge clk) begin
    if (wrEn) begin
      bankMem[wrBank][wrPtr] <= z.data;
    end
    if (rdEn) begin
      tData <= bankMem[rdBank][rdAddr];
    end
  end

  assign t.valid = tValid;
  assign t.data  = tData;

endmodule
